//--- tests/bp_stimulus.mem
// stall pc pc_id pc_ex resolve{en,res} rollback{id,ex} btb_en btb_pc btb_target
// exp_count exp_count_id exp_count_ex exp_taken exp_hit exp_target
0 00000010 00000000 00000000 0 0 0 00000000 00000000 1 1 1 0 0 00000000
0 00000010 00000000 00000000 2 0 0 00000000 00000000 1 1 1 0 0 00000000
0 00000010 00000000 00000000 2 0 0 00000000 00000000 2 1 1 0 0 00000000
0 00000010 00000000 00000000 2 0 0 00000000 00000000 3 2 1 0 0 00000000
0 00000010 00000000 00000000 3 0 0 00000000 00000000 3 3 2 0 0 00000000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 1 3 3 0 0 00000000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 1 1 3 0 0 00000000
0 00000020 00000000 00000020 0 1 0 00000000 00000000 1 1 1 0 0 00000000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 2 1 1 0 0 00000000
0 00000020 00000030 00000020 0 3 0 00000000 00000000 2 2 1 0 0 00000000
0 00000020 00000000 00000010 0 1 0 00000000 00000000 1 2 2 0 0 00000000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 0 1 2 0 0 00000000
0 00000030 00000000 00000000 0 0 0 00000000 00000000 2 0 1 0 0 00000000
0 00000010 00000000 00000000 0 0 0 00000000 00000000 3 2 0 0 0 00000000
0 00000010 00000030 00000030 0 2 0 00000000 00000000 3 3 2 0 0 00000000
0 00000030 00000000 00000000 0 0 0 00000000 00000000 2 3 3 0 0 00000000
1 00000020 00000000 00000000 0 0 0 00000000 00000000 0 2 3 0 0 00000000
1 00000020 00000000 00000000 0 0 0 00000000 00000000 0 2 3 0 0 00000000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 0 2 3 0 0 00000000
0 00000010 00000000 00000000 0 0 1 00000010 00004000 3 0 2 0 0 00000000
0 00000010 00000000 00000000 0 0 1 00000020 00008000 3 3 0 1 1 00004000
0 00000020 00000000 00000000 0 0 0 00000000 00000000 0 3 3 0 1 00008000
0 00000110 00000000 00000000 0 0 0 00000000 00000000 3 0 3 0 0 00000000

//--- list.f
hw/bp_cfg_pkg.sv
hw/bp_types_pkg.sv
hw/prediction_table.sv
hw/history_predictor.sv
hw/branch_target_buffer.sv
hw/bp_top.sv
tests/bp_clock_gen.sv
tests/bp_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module bp_tb -f list.f -o bp_sim
	./obj_dir/bp_sim > sim.log
	cat sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bp_tb;
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  localparam int NUM_VECTORS = 23;
  localparam int FIELDS = 15;  // Words per stimulus line.
  localparam int PERIOD_NS = 40;
  localparam int RESET_CYCLES = 3;
  localparam int MARGIN_CYCLES = 20;

  logic           clk;
  logic           rst_n;
  logic           stall;
  bp_stage_pcs_t  pcs;
  bp_resolve_t    resolve;
  bp_rollback_t   rollback;
  btb_update_t    btb_upd;
  bp_prediction_t pred;

  logic [31:0] stim [NUM_VECTORS*FIELDS];
  int          errors;
  int          checks;

  bp_clock_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  bp_top #(
    .INDEX_WIDTH     (DEF_INDEX_WIDTH),
    .HISTORY_WIDTH   (DEF_HISTORY_WIDTH),
    .BTB_INDEX_WIDTH (DEF_BTB_INDEX_WIDTH),
    .COUNTER_INIT    (2'd1)
  ) u_bp_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .pcs      (pcs),
    .resolve  (resolve),
    .rollback (rollback),
    .btb_upd  (btb_upd),
    .pred     (pred)
  );

  function automatic string test_name_of(input int v);
    if (v == 0)
      return "reset";
    else if (v <= 6)
      return "saturation_history";
    else if (v <= 15)
      return "rollback";
    else if (v <= 18)
      return "stage_lag_stall";
    else
      return "target_buffer";
  endfunction

  task automatic apply_vector(input int v);
    int b;
    b = v * FIELDS;
    stall          = stim[b][0];
    pcs.pc         = stim[b+1];
    pcs.pc_id      = stim[b+2];
    pcs.pc_ex      = stim[b+3];
    resolve        = stim[b+4][1:0];  // {en, result}.
    rollback       = stim[b+5][1:0];  // {id, ex}.
    btb_upd.en     = stim[b+6][0];
    btb_upd.pc     = stim[b+7];
    btb_upd.target = stim[b+8];
  endtask

  task automatic check_field(input int v, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("CHECK FAILED %s vector %0d %s expected %h actual %h",
               test_name_of(v), v, field, expected, actual);
    end
  endtask

  task automatic compare_vector(input int v);
    int b;
    b = v * FIELDS;
    check_field(v, "count", stim[b+9], 32'(pred.count));
    check_field(v, "count_id", stim[b+10], 32'(pred.count_id));
    check_field(v, "count_ex", stim[b+11], 32'(pred.count_ex));
    check_field(v, "taken", stim[b+12], 32'(pred.taken));
    check_field(v, "hit", stim[b+13], 32'(pred.hit));
    check_field(v, "target", stim[b+14], pred.target);
  endtask

  initial
  begin
    errors   = 0;
    checks   = 0;
    stall    = 1'b0;
    pcs      = '0;
    resolve  = '0;
    rollback = '0;
    btb_upd  = '0;
    $readmemh("tests/bp_stimulus.mem", stim);
    if ($isunknown(stim[NUM_VECTORS*FIELDS-1]))
    begin
      errors++;
      $display("Stimulus file is missing or shorter than expected");
    end
    @(posedge rst_n);
    for (int v = 0; v < NUM_VECTORS; v++)
    begin
      apply_vector(v);
      #(PERIOD_NS - 4);  // Just before the next edge.
      compare_vector(v);
      @(posedge clk);
      #2;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

  initial
  begin
    #((RESET_CYCLES + NUM_VECTORS + MARGIN_CYCLES) * PERIOD_NS);
    $display("Timeout, the run did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/bp_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bp_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
)(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;  // Released with the first vector.
  end

endmodule

`default_nettype wire

//--- hw/bp_top.sv
`timescale 1ns/1ps
`default_nettype none

module bp_top #(
  parameter int                                   INDEX_WIDTH     = bp_cfg_pkg::DEF_INDEX_WIDTH,
  parameter int                                   HISTORY_WIDTH   = bp_cfg_pkg::DEF_HISTORY_WIDTH,
  parameter int                                   BTB_INDEX_WIDTH = bp_cfg_pkg::DEF_BTB_INDEX_WIDTH,
  parameter logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] COUNTER_INIT    = 1
)(
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                stall,
  input  wire  bp_types_pkg::bp_stage_pcs_t  pcs,
  input  wire  bp_types_pkg::bp_resolve_t    resolve,
  input  wire  bp_types_pkg::bp_rollback_t   rollback,
  input  wire  bp_types_pkg::btb_update_t    btb_upd,
  output bp_types_pkg::bp_prediction_t       pred
);
  import bp_cfg_pkg::*;

  logic [COUNTER_WIDTH-1:0] count;
  logic [COUNTER_WIDTH-1:0] count_id;
  logic [COUNTER_WIDTH-1:0] count_ex;
  logic                     hit;
  logic [PC_WIDTH-1:0]      target;

  history_predictor #(
    .INDEX_WIDTH   (INDEX_WIDTH),
    .HISTORY_WIDTH (HISTORY_WIDTH),
    .COUNTER_INIT  (COUNTER_INIT)
  ) u_history_predictor (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .pcs      (pcs),
    .resolve  (resolve),
    .rollback (rollback),
    .count    (count),
    .count_id (count_id),
    .count_ex (count_ex)
  );

  branch_target_buffer #(
    .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
  ) u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .lookup_pc (pcs.pc),
    .update    (btb_upd),
    .hit       (hit),
    .target    (target)
  );

  assign pred.count = count;
  assign pred.count_id = count_id;
  assign pred.count_ex = count_ex;
  assign pred.taken = count[COUNTER_WIDTH-1] & hit;  // No target, no redirect.
  assign pred.hit = hit;
  assign pred.target = target;

endmodule

`default_nettype wire

//--- hw/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_INDEX_WIDTH = bp_cfg_pkg::DEF_BTB_INDEX_WIDTH
)(
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [bp_cfg_pkg::PC_WIDTH-1:0] lookup_pc,
  input  wire  bp_types_pkg::btb_update_t update,
  output logic                            hit,
  output logic [bp_cfg_pkg::PC_WIDTH-1:0] target
);
  import bp_cfg_pkg::*;

  localparam int DEPTH = 1 << BTB_INDEX_WIDTH;
  localparam int TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - 2;

  logic [DEPTH-1:0]           valid_q;
  logic [TAG_WIDTH-1:0]       tag_q [DEPTH];
  logic [PC_WIDTH-1:0]        target_q [DEPTH];
  logic [BTB_INDEX_WIDTH-1:0] rd_index;
  logic [BTB_INDEX_WIDTH-1:0] wr_index;
  logic [TAG_WIDTH-1:0]       rd_tag;
  logic [TAG_WIDTH-1:0]       wr_tag;

  assign rd_index = lookup_pc[BTB_INDEX_WIDTH+1:2];
  assign rd_tag = lookup_pc[PC_WIDTH-1:BTB_INDEX_WIDTH+2];
  assign wr_index = update.pc[BTB_INDEX_WIDTH+1:2];
  assign wr_tag = update.pc[PC_WIDTH-1:BTB_INDEX_WIDTH+2];

  assign hit = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
  assign target = hit ? target_q[rd_index] : '0;  // Zero on a miss.

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
    end
    else if (update.en)
    begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  // Tag and target store.
  always_ff @(posedge clk)
  begin
    if (update.en)
    begin
      tag_q[wr_index]    <= wr_tag;
      target_q[wr_index] <= update.target;
    end
  end

endmodule

`default_nettype wire

//--- hw/history_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module history_predictor #(
  parameter int                                   INDEX_WIDTH   = bp_cfg_pkg::DEF_INDEX_WIDTH,
  parameter int                                   HISTORY_WIDTH = bp_cfg_pkg::DEF_HISTORY_WIDTH,
  parameter logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] COUNTER_INIT  = 1
)(
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  stall,
  input  wire  bp_types_pkg::bp_stage_pcs_t    pcs,
  input  wire  bp_types_pkg::bp_resolve_t      resolve,
  input  wire  bp_types_pkg::bp_rollback_t     rollback,
  output logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] count,
  output logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] count_id,
  output logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] count_ex
);
  import bp_cfg_pkg::*;

  localparam int HIST_DEPTH = HISTORY_WIDTH + 2;
  localparam int PC_TOP = INDEX_WIDTH - HISTORY_WIDTH + 1;
  localparam logic [COUNTER_WIDTH-1:0] CNT_MAX = '1;

  logic [HIST_DEPTH-1:0]    history_q;
  logic [HIST_DEPTH-1:0]    history_ex;
  logic                     repaired_bit;
  logic [INDEX_WIDTH-1:0]   index;
  logic [INDEX_WIDTH-1:0]   index_id;
  logic [INDEX_WIDTH-1:0]   index_ex_rid;
  logic [INDEX_WIDTH-1:0]   index_ex_nrid;
  logic                     index_conflict;
  logic [COUNTER_WIDTH-1:0] corr_count;
  logic [COUNTER_WIDTH-1:0] rb_count;
  logic                     wr1_en;
  logic                     wr2_en;
  logic [INDEX_WIDTH-1:0]   wr2_index;
  logic [COUNTER_WIDTH-1:0] wr2_count;

  // Drop the decode-speculated bit when decode also rolls back.
  assign history_ex = history_q >> rollback.rollback_id;
  assign repaired_bit = history_ex[0];

  // PC bits above the word offset, then a window of history per stage.
  assign index = {pcs.pc[PC_TOP:2], history_q[HISTORY_WIDTH-1:0]};
  assign index_id = {pcs.pc_id[PC_TOP:2], history_q[HISTORY_WIDTH:1]};
  assign index_ex_rid = {pcs.pc_ex[PC_TOP:2], history_q[HISTORY_WIDTH+1:2]};
  assign index_ex_nrid = {pcs.pc_ex[PC_TOP:2], history_q[HISTORY_WIDTH:1]};

  assign index_conflict = (index_id == index_ex_rid);

  // Saturating step, result 1 counts down.
  assign corr_count = resolve.corrected_result ?
                      ((count == '0) ? count : count - 1'b1) :
                      ((count == CNT_MAX) ? count : count + 1'b1);

  // Move away from the bit that was wrong.
  assign rb_count = repaired_bit ?
                    ((count_ex == CNT_MAX) ? count_ex : count_ex + 1'b1) :
                    ((count_ex == '0) ? count_ex : count_ex - 1'b1);

  assign wr1_en = rollback.rollback_id && !index_conflict;
  assign wr2_en = rollback.rollback_ex || resolve.corrected_en;
  assign wr2_index = rollback.rollback_ex ?
                     (rollback.rollback_id ? index_ex_rid : index_ex_nrid) : index;
  assign wr2_count = rollback.rollback_ex ? rb_count : corr_count;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count_id  <= COUNTER_INIT;
      count_ex  <= COUNTER_INIT;
      history_q <= '0;
    end
    else
    begin
      if (!stall)
      begin
        count_id <= count;
        count_ex <= count_id;
      end

      if (rollback.rollback_ex)
      begin
        history_q <= {history_ex[HIST_DEPTH-1:1], ~repaired_bit};
      end
      else if (resolve.corrected_en)
      begin
        history_q <= {history_q[HIST_DEPTH-2:0], resolve.corrected_result};
      end
    end
  end

  prediction_table #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .COUNTER_INIT (COUNTER_INIT)
  ) u_table (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_index  (index),
    .rd_count  (count),
    .wr1_en    (wr1_en),
    .wr1_index (index_id),
    .wr1_count (count_id),  // Restore decode's entry as it was read.
    .wr2_en    (wr2_en),
    .wr2_index (wr2_index),
    .wr2_count (wr2_count)
  );

endmodule

`default_nettype wire

//--- hw/prediction_table.sv
`timescale 1ns/1ps
`default_nettype none

module prediction_table #(
  parameter int                                   INDEX_WIDTH  = bp_cfg_pkg::DEF_INDEX_WIDTH,
  parameter logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] COUNTER_INIT = 1
)(
  input  wire                                  clk,
  input  wire                                  rst_n,

  input  wire  [INDEX_WIDTH-1:0]               rd_index,
  output logic [bp_cfg_pkg::COUNTER_WIDTH-1:0] rd_count,

  input  wire                                  wr1_en,
  input  wire  [INDEX_WIDTH-1:0]               wr1_index,
  input  wire  [bp_cfg_pkg::COUNTER_WIDTH-1:0] wr1_count,

  input  wire                                  wr2_en,
  input  wire  [INDEX_WIDTH-1:0]               wr2_index,
  input  wire  [bp_cfg_pkg::COUNTER_WIDTH-1:0] wr2_count
);
  import bp_cfg_pkg::*;

  localparam int DEPTH = 1 << INDEX_WIDTH;

  logic [COUNTER_WIDTH-1:0] counters [DEPTH];

  assign rd_count = counters[rd_index];  // Same-cycle read.

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        counters[i] <= COUNTER_INIT;
      end
    end
    else
    begin
      if (wr1_en)
      begin
        counters[wr1_index] <= wr1_count;
      end
      // Later assignment, so port 2 wins on a collision.
      if (wr2_en)
      begin
        counters[wr2_index] <= wr2_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bp_types_pkg.sv
`default_nettype none

package bp_types_pkg;

  import bp_cfg_pkg::PC_WIDTH;
  import bp_cfg_pkg::COUNTER_WIDTH;

  // PCs of the fetch, decode and execute stages.
  typedef struct packed {
    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] pc_id;
    logic [PC_WIDTH-1:0] pc_ex;
  } bp_stage_pcs_t;

  typedef struct packed {
    logic rollback_id;
    logic rollback_ex;
  } bp_rollback_t;

  // Result of 1 means not taken.
  typedef struct packed {
    logic corrected_en;
    logic corrected_result;
  } bp_resolve_t;

  typedef struct packed {
    logic                en;
    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] target;
  } btb_update_t;

  typedef struct packed {
    logic [COUNTER_WIDTH-1:0] count;
    logic [COUNTER_WIDTH-1:0] count_id;
    logic [COUNTER_WIDTH-1:0] count_ex;
    logic                     taken;
    logic                     hit;
    logic [PC_WIDTH-1:0]      target;
  } bp_prediction_t;

endpackage

`default_nettype wire

//--- hw/bp_cfg_pkg.sv
`default_nettype none

package bp_cfg_pkg;

  // Instruction address width.
  localparam int PC_WIDTH = 32;

  // Saturating direction counter, top bit means taken.
  localparam int COUNTER_WIDTH = 2;

  localparam int DEF_INDEX_WIDTH = 12;  // 4096 counters.
  localparam int DEF_HISTORY_WIDTH = 6;  // History bits mixed into the index.

  localparam int DEF_BTB_INDEX_WIDTH = 6;  // 64 target entries.

endpackage

`default_nettype wire
